// ==== opl3_regs_top.f ====
source/opl3_pkg.sv
source/opl3_host_port.sv
source/opl3_register_bank.sv
source/register_file.sv
source/slot_param_mux.sv
source/opl3_slot_sequencer.sv
source/opl3_regs_top.sv
verification/tb_clock_gen.sv
verification/opl3_regs_assertions.sv
verification/opl3_regs_tb.sv

// ==== Makefile ====
BIN = obj_dir/Vopl3_regs_tb

.PHONY: all run clean

all: run

$(BIN): opl3_regs_top.f $(wildcard source/*.sv verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module opl3_regs_tb -f opl3_regs_top.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== verification/opl3_regs_tb.sv ====
`timescale 1ns/10ps

module opl3_regs_tb import opl3_pkg::*; ();
    localparam int clk_period_ns = 40;
    localparam int reset_cycles = 5;
    localparam int num_random_writes = 48;
    localparam int num_gate_writes = 24;
    localparam int num_global_rounds = 8;
    localparam int num_latch_rounds = 3;
    localparam int sweep_cycles = num_slots + 1;
    localparam int settle_cycles = 2; // pulse, then bank update
    localparam int write_cycles = 2; // address port, then data port
    localparam int test_cycles = (reset_cycles + 2 + sweep_cycles)
        + (num_random_writes * write_cycles + settle_cycles + sweep_cycles)
        + 2 * (num_gate_writes * write_cycles + settle_cycles + sweep_cycles) + write_cycles
        + num_global_rounds * (4 * write_cycles + settle_cycles)
        + num_latch_rounds * (4 * write_cycles + settle_cycles + sweep_cycles);
    localparam int watchdog_ns = 2 * test_cycles * clk_period_ns;
    localparam opl_reg_t op_bases [5] = '{reg_am_vib_base, reg_ksl_tl_base, reg_ar_dr_base,
        reg_sl_rr_base, reg_ws_base};
    localparam opl_reg_t ch_bases [3] = '{reg_fnum_lo_base, reg_kon_block_base,
        reg_feedback_base};

    logic clk, rst_n, host_wr, slot_valid;
    logic [1:0] host_port; // bit 1 bank, bit 0 data
    opl_reg_t host_data;
    global_params_t globals;
    logic [slot_index_width-1:0] out_slot_index;
    operator_params_t op_params;
    channel_params_t ch_params;
    opl_reg_t model_mem [num_banks][num_registers_per_bank]; // reference image of both banks
    opl_reg_t model_latch [num_banks];
    logic model_new_mode;
    opl_reg_t gate_addr_q [$], gate_data_q [$]; // bank 1 writes, replayed in new mode
    int error_count, check_count, tests_run, tests_failed, test_start_errors;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(reset_cycles)) clock_gen0 (
        .clk, .rst_n);

    opl3_regs_top dut0 (.clk, .rst_n, .host_wr, .host_port, .host_data, .globals,
        .slot_valid, .out_slot_index, .op_params, .ch_params);

    bind opl3_regs_top opl3_regs_assertions assertions0 (.clk, .rst_n, .slot_valid,
        .out_slot_index, .reg_write, .reg_write_en, .globals);

    task automatic check_operator(input string name, input operator_params_t got, exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask
    task automatic check_channel(input string name, input channel_params_t got, exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask
    task automatic check_global(input string name, input global_params_t got, exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask
    task automatic check_slot(input string name, input logic [slot_index_width:0] got, exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // operator k of a bank at offset (k/6)*8 + k%6 of each base
    function automatic operator_params_t expected_operator(input int slot);
        int bank;
        int off;
        opl_reg_t av, kt, ad, sr;
        bank = slot / num_operators_per_bank;
        off = (slot % num_operators_per_bank / 6) * 8 + slot % num_operators_per_bank % 6;
        av = model_mem[bank][int'(reg_am_vib_base) + off];
        kt = model_mem[bank][int'(reg_ksl_tl_base) + off];
        ad = model_mem[bank][int'(reg_ar_dr_base) + off];
        sr = model_mem[bank][int'(reg_sl_rr_base) + off];
        return '{am: av[7], vib: av[6], egt: av[5], ksr: av[4], mult: av[3:0],
                 ksl: kt[7:6], tl: kt[5:0], ar: ad[7:4], dr: ad[3:0], sl: sr[7:4],
                 rr: sr[3:0], ws: model_mem[bank][int'(reg_ws_base) + off][2:0]};
    endfunction

    // slot k of a bank plays in channel (k/6)*3 + k%3
    function automatic channel_params_t expected_channel(input int slot);
        int bank;
        int ch;
        opl_reg_t lo, kb, fbc;
        bank = slot / num_operators_per_bank;
        ch = (slot % num_operators_per_bank / 6) * 3 + slot % num_operators_per_bank % 3;
        lo = model_mem[bank][int'(reg_fnum_lo_base) + ch];
        kb = model_mem[bank][int'(reg_kon_block_base) + ch];
        fbc = model_mem[bank][int'(reg_feedback_base) + ch];
        return '{fnum: {kb[1:0], lo}, block: kb[4:2], kon: kb[5], cha: fbc[4], chb: fbc[5],
                 chc: fbc[6], chd: fbc[7], fb: fbc[3:1], cnt: fbc[0]};
    endfunction

    function automatic global_params_t expected_globals();
        opl_reg_t tcr, rhy;
        tcr = model_mem[0][reg_timer_conn];
        rhy = model_mem[0][reg_rhythm];
        return '{mt1: tcr[6], mt2: tcr[5], st1: tcr[0], st2: tcr[1],
                 nts: model_mem[0][reg_kbd_split][6], dam: rhy[7], dvb: rhy[6], ryt: rhy[5],
                 bd: rhy[4], sd: rhy[3], tom: rhy[2], tc: rhy[1], hh: rhy[0],
                 connection_sel: model_mem[1][reg_timer_conn][5:0],
                 is_new: model_mem[1][reg_new_mode][0]};
    endfunction

    function automatic opl_reg_t random_param_addr();
        int sel;
        int k;
        sel = $urandom_range(7);
        k = $urandom_range(num_operators_per_bank - 1);
        if (sel < 5)
            return op_bases[sel] + opl_reg_t'((k / 6) * 8 + k % 6); // holes skipped
        return ch_bases[sel - 5] + opl_reg_t'(k % num_channels_per_bank);
    endfunction

    task automatic idle(input int cycles);
        host_wr = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic write_addr(input logic bank, input opl_reg_t addr);
        host_wr = 1'b1;
        host_port = {bank, 1'b0};
        host_data = addr;
        model_latch[bank] = addr;
        @(negedge clk);
    endtask

    task automatic write_data(input logic bank, input opl_reg_t data);
        opl_reg_t addr;
        addr = model_latch[bank];
        host_wr = 1'b1;
        host_port = {bank, 1'b1};
        host_data = data;
        if (!bank || model_new_mode || addr == reg_new_mode) begin // bank 1 gate
            model_mem[bank][addr] = data;
            if (bank && addr == reg_new_mode)
                model_new_mode = data[0];
        end
        @(negedge clk);
    endtask

    task automatic write_reg(input logic bank, input opl_reg_t addr, input opl_reg_t data);
        write_addr(bank, addr);
        write_data(bank, data);
    endtask

    // one full pass over the 36 slots, starting wherever the sequencer is
    task automatic check_sweep();
        int slot;
        @(negedge clk);
        slot = int'(out_slot_index);
        repeat (num_slots) begin
            check_slot("slot_valid/out_slot_index", {slot_valid, out_slot_index},
                       {1'b1, slot_index_width'(slot)});
            check_operator($sformatf("op_params slot %0d", slot), op_params,
                           expected_operator(slot));
            check_channel($sformatf("ch_params slot %0d", slot), ch_params,
                          expected_channel(slot));
            slot = (slot + 1) % num_slots;
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - test_start_errors;
        tests_run++;
        tests_failed += (errs != 0);
        test_start_errors = error_count;
        $display("test %s finished with %0d errors", name, errs);
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'he758_fa9c));
        {error_count, check_count, tests_run, tests_failed, test_start_errors} = '0;
        host_wr = 1'b0;
        host_port = 2'd0;
        host_data = '0;
        model_mem = '{default: '0};
        model_latch = '{default: '0};
        model_new_mode = 1'b0;

        wait (rst_n === 1'b1); // outputs still hold their reset values here
        check_slot("slot_valid/out_slot_index", {slot_valid, out_slot_index}, '0);
        check_global("globals", globals, '0);
        check_operator("op_params", op_params, '0);
        check_channel("ch_params", ch_params, '0);
        @(negedge clk);
        check_slot("first slot", {slot_valid, out_slot_index}, {1'b1, 6'd0});
        check_sweep(); // valid stays up, all params zero
        end_test("reset");

        repeat (num_random_writes)
            write_reg(1'b0, random_param_addr(), 8'($urandom));
        idle(settle_cycles);
        check_sweep();
        end_test("bank 0 random writes");

        repeat (num_gate_writes) begin
            gate_addr_q.push_back(random_param_addr());
            gate_data_q.push_back(8'($urandom));
            write_reg(1'b1, gate_addr_q[$], gate_data_q[$]); // dropped, mode off
        end
        idle(settle_cycles);
        check_sweep();
        write_reg(1'b1, reg_new_mode, 8'($urandom) | 8'h01);
        foreach (gate_addr_q[i])
            write_reg(1'b1, gate_addr_q[i], gate_data_q[i]);
        idle(settle_cycles);
        check_sweep();
        check_global("globals", globals, expected_globals());
        end_test("bank 1 gate");

        repeat (num_global_rounds) begin
            write_reg(1'b0, reg_timer_conn, 8'($urandom));
            write_reg(1'b0, reg_kbd_split, 8'($urandom));
            write_reg(1'b0, reg_rhythm, 8'($urandom));
            write_reg(1'b1, reg_timer_conn, 8'($urandom)); // connection select
            idle(settle_cycles);
            check_global("globals", globals, expected_globals());
        end
        end_test("global decode");

        for (int i = 0; i < num_latch_rounds; i++) begin
            write_addr(i[0], random_param_addr());
            write_data(i[0], 8'($urandom));
            write_data(i[0], 8'($urandom)); // same latched register
            write_addr(i[0], random_param_addr()); // address only, no data
            idle(settle_cycles);
            check_sweep();
            check_global("globals", globals, expected_globals());
        end
        end_test("address latch");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 check_count, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end
endmodule

// ==== verification/opl3_regs_assertions.sv ====
`timescale 1ns/10ps

module opl3_regs_assertions import opl3_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic slot_valid,
    input logic [slot_index_width-1:0] out_slot_index,
    input reg_write_t reg_write,
    input logic reg_write_en,
    input global_params_t globals
);
    logic [slot_index_width-1:0] next_index; // successor of the current slot

    assign next_index = (out_slot_index == slot_index_width'(num_slots - 1)) ?
        '0 : out_slot_index + 1'b1;

    // synchronous reset, valid is low from the edge after rst_n is seen low
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !slot_valid)
        else $error("slot_valid high during reset");

    slot_order: assert property (@(posedge clk) disable iff (!rst_n)
        slot_valid |=> (out_slot_index == $past(next_index)))
        else $error("out_slot_index did not advance modulo %0d", num_slots);

    // is_new still shows the mode bit as it was before this write
    bank1_gate: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_write_en && reg_write.bank) |->
            (globals.is_new || reg_write.address == reg_new_mode))
        else $error("bank 1 write pulse while new mode is off");
endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns = 40,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk; // first rising edge at half a period
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk); // reset seen on this many edges
        @(negedge clk);
        rst_n = 1'b1; // released on a falling edge
    end
endmodule

// ==== source/opl3_regs_top.sv ====
`timescale 1ns/10ps

module opl3_regs_top import opl3_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic host_wr,
    input  logic [1:0] host_port,
    input  opl_reg_t host_data,
    output global_params_t globals,
    output logic slot_valid,
    output logic [slot_index_width-1:0] out_slot_index,
    output operator_params_t op_params,
    output channel_params_t ch_params
);
    reg_write_t reg_write;
    logic reg_write_en;
    opl_reg_t opl_reg [num_banks][num_registers_per_bank];
    operator_params_t op_params_all [num_slots];
    channel_params_t ch_params_all [num_banks*num_channels_per_bank];
    logic [slot_index_width-1:0] slot_index;
    logic [channel_index_width-1:0] channel_index;

    opl3_host_port host_port0 (
        .clk,
        .rst_n,
        .host_wr,
        .host_port,
        .host_data,
        .reg_write,
        .reg_write_en
    );

    opl3_register_bank register_bank0 (
        .clk,
        .rst_n,
        .reg_write,
        .reg_write_en,
        .opl_reg
    );

    register_file register_file0 (
        .opl_reg,
        .op_params(op_params_all),
        .ch_params(ch_params_all),
        .globals
    );

    opl3_slot_sequencer slot_sequencer0 (
        .clk,
        .rst_n,
        .slot_index,
        .channel_index,
        .slot_valid,
        .out_slot_index
    );

    slot_param_mux #(
        .payload_t(operator_params_t),
        .num_entries(num_slots)
    ) op_mux0 (
        .clk,
        .rst_n,
        .entries(op_params_all),
        .sel(slot_index),
        .selected(op_params)
    );

    slot_param_mux #(
        .payload_t(channel_params_t),
        .num_entries(num_banks * num_channels_per_bank)
    ) ch_mux0 (
        .clk,
        .rst_n,
        .entries(ch_params_all),
        .sel(channel_index),
        .selected(ch_params)
    );
endmodule

// ==== source/opl3_slot_sequencer.sv ====
`timescale 1ns/10ps

module opl3_slot_sequencer import opl3_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    output logic [slot_index_width-1:0] slot_index, // issued to the muxes
    output logic [channel_index_width-1:0] channel_index,
    output logic slot_valid, // aligned with the mux outputs
    output logic [slot_index_width-1:0] out_slot_index
);
    // operator k of a bank sits in channel (k/6)*3 + k%3
    function automatic logic [channel_index_width-1:0] slot_to_channel(
        input logic [slot_index_width-1:0] slot
    );
        logic upper;
        logic [slot_index_width-1:0] op;
        logic [channel_index_width-1:0] ch;
        upper = slot >= slot_index_width'(num_operators_per_bank); // bank 1
        op = upper ? slot - slot_index_width'(num_operators_per_bank) : slot;
        ch = channel_index_width'((op / 6) * 3 + op % 3);
        if (upper)
            ch = ch + channel_index_width'(num_channels_per_bank);
        return ch;
    endfunction

    assign channel_index = slot_to_channel(slot_index);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_index <= '0;
            slot_valid <= 1'b0;
            out_slot_index <= '0;
        end else begin
            if (slot_index == slot_index_width'(num_slots - 1))
                slot_index <= '0; // wrap at 36
            else
                slot_index <= slot_index + 1'b1;
            slot_valid <= 1'b1; // free running, no gaps
            out_slot_index <= slot_index; // matches mux latency
        end
    end
endmodule

// ==== source/slot_param_mux.sv ====
`timescale 1ns/10ps

module slot_param_mux #(
    parameter type payload_t = logic [7:0],
    parameter int num_entries = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  payload_t entries [num_entries],
    input  logic [$clog2(num_entries)-1:0] sel,
    output payload_t selected
);
    payload_t pick; // combinational choice

    // out of range sel returns zero
    always_comb begin
        pick = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (sel == i[$clog2(num_entries)-1:0])
                pick = entries[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            selected <= '0;
        else
            selected <= pick; // one cycle after sel
    end
endmodule

// ==== source/register_file.sv ====
`timescale 1ns/10ps

module register_file import opl3_pkg::*; (
    input  opl_reg_t opl_reg [num_banks][num_registers_per_bank],
    output operator_params_t op_params [num_slots], // bank*18 + operator
    output channel_params_t ch_params [num_banks*num_channels_per_bank], // bank*9 + channel
    output global_params_t globals
);
    // globals live at fixed addresses, mostly in bank 0
    assign globals = '{
        mt1: opl_reg[0][reg_timer_conn][6],
        mt2: opl_reg[0][reg_timer_conn][5],
        st1: opl_reg[0][reg_timer_conn][0],
        st2: opl_reg[0][reg_timer_conn][1],
        nts: opl_reg[0][reg_kbd_split][6],
        dam: opl_reg[0][reg_rhythm][7],
        dvb: opl_reg[0][reg_rhythm][6],
        ryt: opl_reg[0][reg_rhythm][5],
        bd: opl_reg[0][reg_rhythm][4],
        sd: opl_reg[0][reg_rhythm][3],
        tom: opl_reg[0][reg_rhythm][2],
        tc: opl_reg[0][reg_rhythm][1],
        hh: opl_reg[0][reg_rhythm][0],
        connection_sel: opl_reg[1][reg_timer_conn][reg_connection_sel_width-1:0],
        is_new: opl_reg[1][reg_new_mode][0]
    };

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        // operators come in groups of 6, offsets 6,7 and 14,15 unused
        for (genvar k = 0; k < num_operators_per_bank; k++) begin : g_op
            localparam int off = (k / 6) * 8 + k % 6;
            localparam int idx = b * num_operators_per_bank + k;
            opl_reg_t r_am_vib;
            opl_reg_t r_ksl_tl;
            opl_reg_t r_ar_dr;
            opl_reg_t r_sl_rr;
            opl_reg_t r_ws;

            assign r_am_vib = opl_reg[b][int'(reg_am_vib_base) + off];
            assign r_ksl_tl = opl_reg[b][int'(reg_ksl_tl_base) + off];
            assign r_ar_dr = opl_reg[b][int'(reg_ar_dr_base) + off];
            assign r_sl_rr = opl_reg[b][int'(reg_sl_rr_base) + off];
            assign r_ws = opl_reg[b][int'(reg_ws_base) + off];

            assign op_params[idx] = '{
                am: r_am_vib[7],
                vib: r_am_vib[6],
                egt: r_am_vib[5],
                ksr: r_am_vib[4],
                mult: r_am_vib[reg_mult_width-1:0],
                ksl: r_ksl_tl[7:6],
                tl: r_ksl_tl[reg_tl_width-1:0],
                ar: r_ar_dr[7:4],
                dr: r_ar_dr[3:0],
                sl: r_sl_rr[7:4],
                rr: r_sl_rr[3:0],
                ws: r_ws[reg_ws_width-1:0] // upper bits ignored
            };
        end

        for (genvar c = 0; c < num_channels_per_bank; c++) begin : g_ch
            localparam int idx = b * num_channels_per_bank + c;
            opl_reg_t r_fnum_lo;
            opl_reg_t r_kon_block;
            opl_reg_t r_fb;

            assign r_fnum_lo = opl_reg[b][int'(reg_fnum_lo_base) + c];
            assign r_kon_block = opl_reg[b][int'(reg_kon_block_base) + c];
            assign r_fb = opl_reg[b][int'(reg_feedback_base) + c];

            assign ch_params[idx] = '{
                fnum: {r_kon_block[1:0], r_fnum_lo}, // 2 high bits from 0xBx
                block: r_kon_block[4:2],
                kon: r_kon_block[5],
                cha: r_fb[4],
                chb: r_fb[5],
                chc: r_fb[6],
                chd: r_fb[7],
                fb: r_fb[3:1],
                cnt: r_fb[0]
            };
        end
    end
endmodule

// ==== source/opl3_register_bank.sv ====
`timescale 1ns/10ps

module opl3_register_bank import opl3_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  reg_write_t reg_write,
    input  logic reg_write_en,
    output opl_reg_t opl_reg [num_banks][num_registers_per_bank]
);
    opl_reg_t mem [num_banks][num_registers_per_bank]; // 512 bytes

    // chip powers up silent, so every byte clears
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < num_banks; b++) begin
                for (int a = 0; a < num_registers_per_bank; a++) begin
                    mem[b][a] <= '0;
                end
            end
        end else if (reg_write_en) begin
            mem[reg_write.bank][reg_write.address] <= reg_write.data; // single write port
        end
    end

    // all bytes visible in parallel to the decode
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        for (genvar a = 0; a < num_registers_per_bank; a++) begin : g_byte
            assign opl_reg[b][a] = mem[b][a];
        end
    end
endmodule

// ==== source/opl3_host_port.sv ====
`timescale 1ns/10ps

module opl3_host_port import opl3_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic host_wr, // one-cycle strobe
    input  logic [1:0] host_port, // bit 1 bank, bit 0 data
    input  opl_reg_t host_data,
    output reg_write_t reg_write,
    output logic reg_write_en
);
    opl_reg_t addr_latch [num_banks]; // one latched address per bank
    logic new_mode; // local copy of bank 1 reg 0x05 bit 0
    logic port_bank;
    logic port_is_data;
    logic gate_open;
    logic accept;

    assign port_bank = host_port[1];
    assign port_is_data = host_port[0];
    // bank 1 writes only in new mode, 0x05 itself always passes
    assign gate_open = !port_bank || new_mode || (addr_latch[1] == reg_new_mode);
    assign accept = host_wr && port_is_data && gate_open;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_latch[0] <= '0;
            addr_latch[1] <= '0;
            new_mode <= 1'b0;
            reg_write_en <= 1'b0;
        end else begin
            reg_write_en <= accept; // pulse one cycle after the strobe
            if (host_wr && !port_is_data)
                addr_latch[port_bank] <= host_data; // address port
            if (accept && port_bank && addr_latch[1] == reg_new_mode)
                new_mode <= host_data[0];
        end
    end

    // payload follows the pulse, qualified by reg_write_en
    always_ff @(posedge clk) begin
        if (accept) begin
            reg_write.bank <= port_bank;
            reg_write.address <= addr_latch[port_bank];
            reg_write.data <= host_data;
        end
    end
endmodule

// ==== source/opl3_pkg.sv ====
package opl3_pkg;
    // register map sizes
    localparam int num_banks = 2;
    localparam int num_registers_per_bank = 256;
    localparam int num_operators_per_bank = 18;
    localparam int num_channels_per_bank = 9;
    localparam int num_slots = num_banks * num_operators_per_bank; // 36 operator slots
    localparam int slot_index_width = 6;
    localparam int channel_index_width = 5; // 0..17 over both banks

    // field widths
    localparam int reg_fnum_width = 10;
    localparam int reg_mult_width = 4;
    localparam int reg_block_width = 3;
    localparam int reg_ws_width = 3;
    localparam int reg_env_width = 4; // ar, dr, sl, rr
    localparam int reg_tl_width = 6;
    localparam int reg_ksl_width = 2;
    localparam int reg_fb_width = 3;
    localparam int reg_connection_sel_width = 6;

    // operator bases, offsets 0..21 with holes
    localparam logic [7:0] reg_am_vib_base = 8'h20;
    localparam logic [7:0] reg_ksl_tl_base = 8'h40;
    localparam logic [7:0] reg_ar_dr_base = 8'h60;
    localparam logic [7:0] reg_sl_rr_base = 8'h80;
    localparam logic [7:0] reg_ws_base = 8'hE0;
    // channel bases, offsets 0..8
    localparam logic [7:0] reg_fnum_lo_base = 8'hA0;
    localparam logic [7:0] reg_kon_block_base = 8'hB0;
    localparam logic [7:0] reg_feedback_base = 8'hC0;
    // single registers
    localparam logic [7:0] reg_new_mode = 8'h05; // bank 1 only
    localparam logic [7:0] reg_timer_conn = 8'h04; // mt/st in bank 0, 4-op select in bank 1
    localparam logic [7:0] reg_kbd_split = 8'h08;
    localparam logic [7:0] reg_rhythm = 8'hBD;

    typedef logic [7:0] opl_reg_t;

    typedef struct packed {
        logic bank;
        opl_reg_t address;
        opl_reg_t data;
    } reg_write_t;

    typedef struct packed {
        logic am; // tremolo enable
        logic vib; // vibrato enable
        logic egt; // sustaining envelope
        logic ksr; // key scale rate
        logic [reg_mult_width-1:0] mult;
        logic [reg_ksl_width-1:0] ksl; // key scale level
        logic [reg_tl_width-1:0] tl; // total level, attenuation
        logic [reg_env_width-1:0] ar;
        logic [reg_env_width-1:0] dr;
        logic [reg_env_width-1:0] sl;
        logic [reg_env_width-1:0] rr;
        logic [reg_ws_width-1:0] ws; // waveform select
    } operator_params_t;

    typedef struct packed {
        logic [reg_fnum_width-1:0] fnum;
        logic [reg_block_width-1:0] block; // octave
        logic kon; // key on
        logic cha; // output routing, left
        logic chb; // right
        logic chc;
        logic chd;
        logic [reg_fb_width-1:0] fb; // modulator feedback
        logic cnt; // fm or additive
    } channel_params_t;

    typedef struct packed {
        logic mt1; // timer masks
        logic mt2;
        logic st1; // timer starts
        logic st2;
        logic nts; // note select, keyboard split
        logic dam; // tremolo depth
        logic dvb; // vibrato depth
        logic ryt; // percussion mode
        logic bd;
        logic sd;
        logic tom;
        logic tc;
        logic hh;
        logic [reg_connection_sel_width-1:0] connection_sel;
        logic is_new; // opl3 mode
    } global_params_t;
endpackage
